//--- list.f
+incdir+rtl
rtl/adc_rx_pkg.sv
rtl/lane_ctl_if.sv
rtl/lane_ctl_seq.sv
rtl/lvds_iophy.sv
rtl/lvds_frame.sv
rtl/sample_assemble.sv
rtl/ad9653_rx.sv
dv/tb_ad9653_rx.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ad9653_rx testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_ad9653_rx \
	-f list.f \
	-o sim_tb_ad9653_rx

./obj_dir/sim_tb_ad9653_rx | tee sim.log

if grep -qx 'STATUS: PASS' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- dv/tb_ad9653_rx.sv
`timescale 1ns/1ps

`include "adc_rx_defines.svh"

module tb_ad9653_rx;

	localparam int NCH = `ADC_LANES / 2;

	logic                  dco_clk;
	logic                  arst_n;
	logic [`ADC_LANES-1:0] d_lane;
	logic                  frame;
	logic                  ctl_req;
	adc_rx_pkg::ctl_op_t   ctl_op;
	adc_rx_pkg::lane_idx_t ctl_lane;
	adc_rx_pkg::tap_t      ctl_tap;
	logic                  ctl_ack;
	adc_rx_pkg::samples_t  dout;
	logic                  dout_valid;
	logic                  locked;

	logic [31:0]           lfsr;
	int                    early [`ADC_LANES]; // bits a lane runs ahead of the frame lane
	logic                  glitch_req;
	logic                  check_en;
	logic                  resync;
	int                    n_checked;
	int                    offset;
	adc_rx_pkg::samples_t  sent_q [$];

	ad9653_rx i_ad9653_rx (
		.dco_clk    (dco_clk),
		.arst_n     (arst_n),
		.d_lane     (d_lane),
		.frame      (frame),
		.ctl_req    (ctl_req),
		.ctl_op     (ctl_op),
		.ctl_lane   (ctl_lane),
		.ctl_tap    (ctl_tap),
		.ctl_ack    (ctl_ack),
		.dout       (dout),
		.dout_valid (dout_valid),
		.locked     (locked)
	);

	initial begin
		dco_clk = 1'b0;
		forever #10 dco_clk = ~dco_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] lfsr_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// D0 carries the even sample bits and D1 the odd ones
	function automatic adc_rx_pkg::lane_word_t lane_half(input adc_rx_pkg::sample_t s, input int odd);
		adc_rx_pkg::lane_word_t w;
		for (int i = 0; i < `ADC_WBITS; i++) begin
			w[i] = s[2*i+odd];
		end
		return w;
	endfunction

	// channel A lands in slot 0 of the output word
	function automatic adc_rx_pkg::samples_t expected_samples(input adc_rx_pkg::sample_t smp [NCH]);
		adc_rx_pkg::samples_t s;
		for (int c = 0; c < NCH; c++) begin
			s[c] = smp[c];
		end
		return s;
	endfunction

	function automatic void draw_words(output adc_rx_pkg::lane_word_t [`ADC_LANES-1:0] w,
		output adc_rx_pkg::samples_t set);
		adc_rx_pkg::sample_t smp [NCH];
		for (int c = 0; c < NCH; c++) begin
			smp[c]   = lfsr_bits(16);
			w[2*c]   = lane_half(smp[c], 0);
			w[2*c+1] = lane_half(smp[c], 1);
		end
		set = expected_samples(smp);
	endfunction

	// endless serial stream, one word of every lane per frame, MSB first
	task automatic stream_words(input int start_bits);
		adc_rx_pkg::lane_word_t [`ADC_LANES-1:0] cur_w;
		adc_rx_pkg::lane_word_t [`ADC_LANES-1:0] nxt_w;
		adc_rx_pkg::samples_t                    nxt_set;
		adc_rx_pkg::lane_word_t                  frm_w;
		logic [`ADC_LANES-1:0]                   bits;
		int                                      idx;
		repeat (start_bits) @(posedge dco_clk);
		draw_words(nxt_w, nxt_set);
		forever begin
			cur_w = nxt_w;
			sent_q.push_back(nxt_set);
			draw_words(nxt_w, nxt_set);
			frm_w      = glitch_req ? ~`ADC_FRAME_PAT : `ADC_FRAME_PAT;
			glitch_req = 1'b0;
			for (int j = 0; j < `ADC_WBITS; j++) begin
				for (int k = 0; k < `ADC_LANES; k++) begin
					idx     = j + early[k]; // an early lane borrows from the next word
					bits[k] = (idx < 8) ? cur_w[k][7-idx] : nxt_w[k][15-idx];
				end
				@(posedge dco_clk);
				d_lane <= bits;
				frame  <= frm_w[7-j];
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks and waits

	task automatic halt_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_samples(input string name, input adc_rx_pkg::samples_t got,
		input adc_rx_pkg::samples_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			halt_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			halt_run();
		end
	endtask

	task automatic wait_ack(input logic val, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge dco_clk);
			n++;
			if (ctl_ack !== val && n >= limit) begin
				$display("timed out waiting for ctl_ack to become %b", val);
				halt_run();
			end
		end while (ctl_ack !== val);
	endtask

	task automatic wait_locked(input logic val, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge dco_clk);
			n++;
			if (locked !== val && n >= limit) begin
				$display("timed out after %0d cycles waiting for locked to become %b", n, val);
				halt_run();
			end
		end while (locked !== val);
	endtask

	task automatic wait_more_checks(input int count);
		int target;
		int n;
		target = n_checked + count;
		n      = 0;
		while (n_checked < target) begin
			@(posedge dco_clk);
			n++;
			if (n > (count + 8) * `ADC_WBITS) begin
				$display("timed out waiting for %0d more output samples", count);
				halt_run();
			end
		end
	endtask

	// one full four-phase request on the host port
	task automatic host_cmd(input adc_rx_pkg::ctl_op_t op, input adc_rx_pkg::lane_idx_t lane,
		input adc_rx_pkg::tap_t tap);
		@(negedge dco_clk);
		check_bit("ctl_ack", ctl_ack, 1'b0);
		@(posedge dco_clk);
		ctl_op   <= op;
		ctl_lane <= lane;
		ctl_tap  <= tap;
		ctl_req  <= 1'b1;
		wait_ack(1'b1, 8);
		repeat (2) begin
			@(negedge dco_clk);
			check_bit("ctl_ack", ctl_ack, 1'b1); // held while req stays high
		end
		@(posedge dco_clk);
		ctl_req <= 1'b0;
		@(negedge dco_clk);
		check_bit("ctl_ack", ctl_ack, 1'b1);
		wait_ack(1'b0, 8);
	endtask

	//////////////////////////////////////////////////////////////////////
	// output comparison

	always @(negedge dco_clk) begin : compare_outputs
		adc_rx_pkg::samples_t want;
		if (arst_n && dout_valid && check_en) begin
			if (resync) begin // skip words that were sent while unlocked
				while (sent_q.size() > 0 && sent_q[0] !== dout) begin
					void'(sent_q.pop_front());
				end
				if (sent_q.size() == 0) begin
					$display("no sent sample set matches the first output %h after lock", dout);
					halt_run();
				end
				resync = 1'b0;
			end
			if (sent_q.size() == 0) begin
				$display("dout_valid came with no sample set left to match");
				halt_run();
			end
			want = sent_q.pop_front();
			check_samples("dout", dout, want);
			n_checked++;
		end
	end

	initial begin : main
		arst_n     = 1'b0;
		d_lane     = '0;
		frame      = 1'b0;
		ctl_req    = 1'b0;
		ctl_op     = adc_rx_pkg::OP_TAP_LOAD;
		ctl_lane   = '0;
		ctl_tap    = '0;
		lfsr       = 32'hfaaa_0837;
		glitch_req = 1'b0;
		check_en   = 1'b1;
		resync     = 1'b1;
		n_checked  = 0;
		for (int k = 0; k < `ADC_LANES; k++) begin
			early[k] = 0;
		end
		repeat (3) @(posedge dco_clk);
		arst_n <= 1'b1;
		offset = int'(lfsr_bits(3));
		fork
			stream_words(offset);
		join_none

		wait_locked(1'b1, 64 * `ADC_WBITS);
		wait_more_checks(40);

		// lanes 5 and 2 arrive three bits early and the taps pull them back
		@(posedge dco_clk);
		check_en = 1'b0;
		@(negedge dco_clk);
		early[5] = 3;
		early[2] = 3;
		host_cmd(adc_rx_pkg::OP_TAP_LOAD, 3'd5, 5'd3);
		repeat (3) host_cmd(adc_rx_pkg::OP_TAP_INC, 3'd2, 5'd0);
		repeat (4 * `ADC_WBITS) @(posedge dco_clk);
		check_bit("locked", locked, 1'b1);
		resync   = 1'b1;
		check_en = 1'b1;
		wait_more_checks(40);

		// a corrupted frame word breaks lock
		@(negedge dco_clk);
		glitch_req = 1'b1;
		wait_locked(1'b0, 4 * `ADC_WBITS);
		@(posedge dco_clk);
		resync = 1'b1;
		wait_locked(1'b1, 64 * `ADC_WBITS);
		wait_more_checks(40);

		@(posedge dco_clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- rtl/ad9653_rx.sv
`timescale 1ns/1ps

`include "adc_rx_defines.svh"

module ad9653_rx (
	input  logic                       dco_clk,
	input  logic                       arst_n,
	input  logic [`ADC_LANES-1:0]      d_lane,
	input  logic                       frame,
	input  logic                       ctl_req,
	input  adc_rx_pkg::ctl_op_t        ctl_op,
	input  adc_rx_pkg::lane_idx_t      ctl_lane,
	input  adc_rx_pkg::tap_t           ctl_tap,
	output logic                       ctl_ack,
	output logic [8*`ADC_LANES-1:0]    dout,
	output logic                       dout_valid,
	output logic                       locked
);

	logic                                    word_stb;
	adc_rx_pkg::lane_word_t [`ADC_LANES-1:0] lane_words;
	adc_rx_pkg::samples_t                    samples;

	lane_ctl_if i_lane_ctl_if ();

	//////////////////////////////////////////////////////////////////////
	// host tap control

	lane_ctl_seq i_lane_ctl_seq (
		.dco_clk  (dco_clk),
		.arst_n   (arst_n),
		.ctl_req  (ctl_req),
		.ctl_op   (ctl_op),
		.ctl_lane (ctl_lane),
		.ctl_tap  (ctl_tap),
		.ctl_ack  (ctl_ack),
		.ctl      (i_lane_ctl_if.seq)
	);

	//////////////////////////////////////////////////////////////////////
	// lanes

	// lane order is D0A, D1A, D0B, D1B and so on up to D1D
	genvar gi;
	generate
		for (gi = 0; gi < `ADC_LANES; gi++) begin : g_lane
			lvds_iophy #(
				.LANE_ID (gi)
			) i_lvds_iophy (
				.dco_clk  (dco_clk),
				.arst_n   (arst_n),
				.d        (d_lane[gi]),
				.word_stb (word_stb),
				.ctl      (i_lane_ctl_if.lane),
				.dout     (lane_words[gi])
			);
		end
	endgenerate

	lvds_frame i_lvds_frame (
		.dco_clk  (dco_clk),
		.arst_n   (arst_n),
		.frame    (frame),
		.word_stb (word_stb),
		.locked   (locked)
	);

	sample_assemble i_sample_assemble (
		.dco_clk    (dco_clk),
		.arst_n     (arst_n),
		.word_stb   (word_stb),
		.locked     (locked),
		.lane_words (lane_words),
		.dout       (samples),
		.dout_valid (dout_valid)
	);

	assign dout = samples; // channel A in the low 16 bits

endmodule

//--- rtl/sample_assemble.sv
`timescale 1ns/1ps

`include "adc_rx_defines.svh"

module sample_assemble (
	input  logic                                      dco_clk,
	input  logic                                      arst_n,
	input  logic                                      word_stb,
	input  logic                                      locked,
	input  adc_rx_pkg::lane_word_t [`ADC_LANES-1:0]   lane_words,
	output adc_rx_pkg::samples_t                      dout,
	output logic                                      dout_valid
);

	localparam int NCH = `ADC_LANES / 2;

	logic                 stb_q;
	adc_rx_pkg::samples_t merged;

	//////////////////////////////////////////////////////////////////////
	// two-lane de-interleave

	// channel c takes D0 from lane 2c and D1 from lane 2c+1
	always_comb begin
		for (int c = 0; c < NCH; c++) begin
			for (int i = 0; i < `ADC_WBITS; i++) begin
				merged[c][2*i+1] = lane_words[2*c+1][i]; // odd sample bits ride on D1
				merged[c][2*i]   = lane_words[2*c][i];
			end
		end
	end

	// lane words land on the edge that closes word_stb
	always_ff @(posedge dco_clk or negedge arst_n) begin
		if (!arst_n) begin
			stb_q      <= 1'b0;
			dout_valid <= 1'b0;
		end else begin
			stb_q      <= word_stb;
			dout_valid <= stb_q && locked;
		end
	end

	always_ff @(posedge dco_clk) begin
		if (stb_q && locked) begin
			dout <= merged;
		end
	end

endmodule

//--- rtl/lvds_frame.sv
`timescale 1ns/1ps

`include "adc_rx_defines.svh"

module lvds_frame (
	input  logic dco_clk,
	input  logic arst_n,
	input  logic frame,
	output logic word_stb,
	output logic locked
);

	typedef enum logic [1:0] {
		F_HUNT,
		F_SKIP,
		F_TRACK
	} fstate_t;

	fstate_t                              state;
	adc_rx_pkg::lane_word_t               fsr;
	logic [$clog2(`ADC_WBITS)-1:0]        bit_cnt;
	logic                                 hold;
	logic [1:0]                           skip_cnt;
	logic [$clog2(`ADC_LOCK_CNT+1)-1:0]   match_cnt;
	logic                                 match;

	assign match = (fsr == `ADC_FRAME_PAT);

	always_ff @(posedge dco_clk) begin
		fsr <= {fsr[`ADC_WBITS-2:0], frame};
	end

	//////////////////////////////////////////////////////////////////////
	// shared word boundary

	// a held count stretches one word by a bit on every lane at once
	always_ff @(posedge dco_clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt  <= '0;
			word_stb <= 1'b0;
		end else begin
			word_stb <= (bit_cnt == '1) && !hold;
			if (!hold) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bitslip hunting and lock

	always_ff @(posedge dco_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= F_HUNT;
			hold      <= 1'b0;
			skip_cnt  <= '0;
			match_cnt <= '0;
			locked    <= 1'b0;
		end else begin
			hold <= 1'b0;
			if (word_stb) begin
				case (state)
					F_HUNT: begin
						if (match) begin
							match_cnt <= 1'b1;
							state     <= F_TRACK;
						end else begin
							hold     <= 1'b1; // slip one bit
							skip_cnt <= 2'd2; // the next two words may be torn
							state    <= F_SKIP;
						end
					end
					F_SKIP: begin
						skip_cnt <= skip_cnt - 1'b1;
						if (skip_cnt == 2'd1) begin
							state <= F_HUNT;
						end
					end
					F_TRACK: begin
						if (!match) begin
							locked    <= 1'b0;
							match_cnt <= '0;
							state     <= F_HUNT;
						end else if (match_cnt == ($bits(match_cnt))'(`ADC_LOCK_CNT - 1)) begin
							locked <= 1'b1;
						end else begin
							match_cnt <= match_cnt + 1'b1;
						end
					end
					default: state <= F_HUNT;
				endcase
			end
		end
	end

	a_stb_spacing: assert property (@(posedge dco_clk) disable iff (!arst_n)
		word_stb |=> !word_stb [*7]);

endmodule

//--- rtl/lvds_iophy.sv
`timescale 1ns/1ps

`include "adc_rx_defines.svh"

module lvds_iophy #(
	parameter int LANE_ID = 0
) (
	input  logic                   dco_clk,
	input  logic                   arst_n,
	input  logic                   d,
	input  logic                   word_stb,
	lane_ctl_if.lane               ctl,
	output adc_rx_pkg::lane_word_t dout
);

	localparam int NTAPS = 2**`ADC_TAPW;

	logic                   hit;
	adc_rx_pkg::tap_t       tap_q;
	logic [NTAPS-1:1]       dline;
	logic [NTAPS-1:0]       taps;
	logic                   dly_bit;
	adc_rx_pkg::lane_word_t sreg;

	assign hit = (ctl.lane_sel == adc_rx_pkg::lane_idx_t'(LANE_ID));

	//////////////////////////////////////////////////////////////////////
	// tap register

	always_ff @(posedge dco_clk or negedge arst_n) begin
		if (!arst_n) begin
			tap_q <= '0;
		end else if (hit && ctl.ld) begin
			tap_q <= ctl.tap;
		end else if (hit && ctl.ce && tap_q != '1) begin // stays at the last tap
			tap_q <= tap_q + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// delay line and deserializer

	// position k of the tap vector is d seen k cycles late
	assign taps    = {dline, d};
	assign dly_bit = taps[tap_q];

	always_ff @(posedge dco_clk) begin
		dline <= {dline[NTAPS-2:1], d};
		sreg  <= {sreg[`ADC_WBITS-2:0], dly_bit}; // MSB arrives first
		if (word_stb) begin
			dout <= sreg;
		end
	end

	// one command at a time comes out of the sequencer
	a_ld_ce_excl: assert property (@(posedge dco_clk) disable iff (!arst_n)
		!(ctl.ld && ctl.ce));

endmodule

//--- rtl/lane_ctl_seq.sv
`timescale 1ns/1ps

module lane_ctl_seq (
	input  logic                  dco_clk,
	input  logic                  arst_n,
	input  logic                  ctl_req,
	input  adc_rx_pkg::ctl_op_t   ctl_op,
	input  adc_rx_pkg::lane_idx_t ctl_lane,
	input  adc_rx_pkg::tap_t      ctl_tap,
	output logic                  ctl_ack,
	lane_ctl_if.seq               ctl
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_STROBE,
		S_WAIT
	} state_t;

	state_t state;
	logic   req_q1;
	logic   req_q2;
	logic   ack_q;
	logic   req_rise;

	assign req_rise = req_q1 & ~req_q2;

	// ack drops as soon as the synchronized request is seen low
	assign ctl_ack = ack_q & req_q1;

	//////////////////////////////////////////////////////////////////////
	// request handshake

	always_ff @(posedge dco_clk or negedge arst_n) begin
		if (!arst_n) begin
			req_q1 <= 1'b0;
			req_q2 <= 1'b0;
			ack_q  <= 1'b0;
			ctl.ld <= 1'b0;
			ctl.ce <= 1'b0;
			state  <= S_IDLE;
		end else begin
			req_q1 <= ctl_req;
			req_q2 <= req_q1;
			case (state)
				S_IDLE: begin
					if (req_rise) begin
						ctl.ld <= (ctl_op == adc_rx_pkg::OP_TAP_LOAD);
						ctl.ce <= (ctl_op == adc_rx_pkg::OP_TAP_INC);
						state  <= S_STROBE;
					end
				end
				S_STROBE: begin // strobe has been out for exactly one cycle
					ctl.ld <= 1'b0;
					ctl.ce <= 1'b0;
					ack_q  <= 1'b1;
					state  <= S_WAIT;
				end
				S_WAIT: begin
					if (!req_q1) begin
						ack_q <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// host holds lane and tap stable while req is high
	always_ff @(posedge dco_clk) begin
		if (state == S_IDLE && req_rise) begin
			ctl.lane_sel <= ctl_lane;
			ctl.tap      <= ctl_tap;
		end
	end

	a_ack_after_req: assert property (@(posedge dco_clk) disable iff (!arst_n)
		$rose(ctl_ack) |-> ctl_req);

endmodule

//--- rtl/lane_ctl_if.sv
`timescale 1ns/1ps

// tap commands fanned out from the sequencer to every data lane
interface lane_ctl_if;

	logic                  ld;       // load tap into the addressed lane
	logic                  ce;       // increment the addressed lane's tap
	adc_rx_pkg::lane_idx_t lane_sel; // which lane the strobe is meant for
	adc_rx_pkg::tap_t      tap;

	modport seq (
		output ld,
		output ce,
		output lane_sel,
		output tap
	);

	modport lane (
		input ld,
		input ce,
		input lane_sel,
		input tap
	);

endinterface

//--- rtl/adc_rx_pkg.sv
`include "adc_rx_defines.svh"

package adc_rx_pkg;

	//////////////////////////////////////////////////////////////////////
	// datapath words

	typedef logic [`ADC_WBITS-1:0] lane_word_t;

	typedef logic [2*`ADC_WBITS-1:0] sample_t; // D1 and D0 bits interleaved

	// channel A sits in slot 0
	typedef sample_t [`ADC_LANES/2-1:0] samples_t;

	//////////////////////////////////////////////////////////////////////
	// host control

	typedef logic [`ADC_TAPW-1:0] tap_t;

	typedef logic [$clog2(`ADC_LANES)-1:0] lane_idx_t;

	typedef enum logic {
		OP_TAP_LOAD = 1'b0, // write an absolute tap value
		OP_TAP_INC  = 1'b1  // step the tap up by one
	} ctl_op_t;

endpackage

//--- rtl/adc_rx_defines.svh
`ifndef ADC_RX_DEFINES_SVH
`define ADC_RX_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// serial ADC receive geometry

// two lanes per channel and four channels
`define ADC_LANES 8

// each lane carries half a 16-bit sample per frame
`define ADC_WBITS 8

// delay line reaches 0 to 31 taps
`define ADC_TAPW 5

//////////////////////////////////////////////////////////////////////
// frame alignment

// the frame lane is high for the first half of every word
`define ADC_FRAME_PAT 8'hF0

// matching frame words in a row before the stream counts as locked
`define ADC_LOCK_CNT 4

`endif
